//--- project.f
+incdir+.
ram_port_pkg.sv
ram_bank_pkg.sv
write_lane_steer.sv
read_lane_select.sv
bank_array.sv
asym_ram_top.sv
asym_ram_tb.sv

//--- Bender.yml
package:
  name: asym_ram

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ram_port_pkg.sv
      - ram_bank_pkg.sv
      - write_lane_steer.sv
      - read_lane_select.sv
      - bank_array.sv
      - asym_ram_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - asym_ram_tb.sv

//--- asym_ram_tb.sv
`timescale 1ns/10ps
`include "asym_ram_macros.svh"

module asym_ram_tb
   import ram_port_pkg::*;
();

   localparam int clk_period = 100;
   localparam int drive_delay = 10;
   localparam int reset_cycles = 10;
   localparam int fill_cycles = 1 << `RAM_WADDR_W;
   localparam int directed_cycles = 40;
   localparam int random_cycles = 300;
   localparam int total_cycles = reset_cycles + fill_cycles + directed_cycles + random_cycles + 10;
   localparam byte_addr_t random_base = 10'h080;

   logic                   clk;
   logic                   rst;
   wr_req_t                wr;
   rd_req_t                rd;
   logic [`RAM_BYTE_W-1:0] r_data;

   // byte-wide model of the whole RAM and the byte due after each read
   logic [`RAM_BYTE_W-1:0] model [1 << `RAM_BADDR_W];
   logic [`RAM_BYTE_W-1:0] exp_q;

   integer seed;
   int     err_count;
   int     err_at_start;
   int     tests_passed;
   int     tests_failed;

   asym_ram_top asym_ram_top_i (
      .clk    (clk),
      .rst    (rst),
      .wr     (wr),
      .rd     (rd),
      .r_data (r_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   // byte value depending on every address bit
   function automatic logic [`RAM_BYTE_W-1:0] fill_byte(input byte_addr_t a);
      return a[7:0] ^ {4{a[9:8]}};
   endfunction

   task automatic update_model(input wr_req_t req);
      byte_addr_t a;
      if (req.size == size_word) begin
         for (int l = 0; l < `RAM_LANES; l++) begin
            if (req.strb[l]) begin
               a = {req.addr[`RAM_BADDR_W-1:2], 2'(l)};
               model[a] = req.data[`RAM_BYTE_W*l +: `RAM_BYTE_W];
            end
         end
      end else begin
         model[req.addr] = req.data[`RAM_BYTE_W-1:0];
      end
   endtask

   // read takes the byte before this edge's write
   always @(posedge clk) begin
      if (rst) begin
         exp_q <= '0;
      end else begin
         if (rd.en) begin
            exp_q <= model[rd.addr];
         end
         if (wr.en) begin
            update_model(wr);
         end
      end
   end

   task automatic report_mismatch(input logic [`RAM_BYTE_W-1:0] got,
                                  input logic [`RAM_BYTE_W-1:0] want);
      err_count++;
      $display("mismatch r_data 0x%h expected 0x%h at %0t", got, want, $time);
   endtask

   a_read_data : assert property (@(posedge clk) disable iff (rst)
      $past(rd.en) |-> r_data == exp_q)
   else report_mismatch($sampled(r_data), $sampled(exp_q));

   // idle cycles keep the last byte
   a_read_hold : assert property (@(posedge clk) disable iff (rst)
      !$past(rd.en) |-> r_data == exp_q)
   else report_mismatch($sampled(r_data), $sampled(exp_q));

   a_reset_zero : assert property (@(posedge clk) $fell(rst) |-> r_data == '0)
   else report_mismatch($sampled(r_data), '0);

   task automatic next_cycle();
      @(posedge clk);
      #(drive_delay);
   endtask

   task automatic idle_inputs();
      wr = '0;
      rd = '0;
   endtask

   task automatic apply_cycle();
      next_cycle();
      idle_inputs();
   endtask

   task automatic drive_word_write(input byte_addr_t addr, input logic [`RAM_WORD_W-1:0] data,
                                   input logic [`RAM_LANES-1:0] strb);
      wr.en = 1'b1;
      wr.size = size_word;
      wr.addr = addr;
      wr.data = data;
      wr.strb = strb;
   endtask

   task automatic drive_byte_write(input byte_addr_t addr, input logic [`RAM_BYTE_W-1:0] data);
      wr.en = 1'b1;
      wr.size = size_byte;
      wr.addr = addr;
      wr.data = {{(`RAM_WORD_W-`RAM_BYTE_W){1'b0}}, data};
      wr.strb = '0;
   endtask

   task automatic drive_read(input byte_addr_t addr);
      rd.en = 1'b1;
      rd.addr = addr;
   endtask

   task automatic read_word_bytes(input byte_addr_t base);
      for (int l = 0; l < `RAM_LANES; l++) begin
         drive_read(base + byte_addr_t'(l));
         apply_cycle();
      end
   endtask

   task automatic fill_memory();
      byte_addr_t a;
      logic [`RAM_WORD_W-1:0] w;
      for (int i = 0; i < fill_cycles; i++) begin
         for (int l = 0; l < `RAM_LANES; l++) begin
            a = {i[`RAM_WADDR_W-1:0], 2'(l)};
            w[`RAM_BYTE_W*l +: `RAM_BYTE_W] = fill_byte(a);
         end
         drive_word_write({i[`RAM_WADDR_W-1:0], 2'b00}, w, 4'hf);
         apply_cycle();
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      repeat (2) apply_cycle();
      errs = err_count - err_at_start;
      if (errs == 0) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, errs);
      end
      err_at_start = err_count;
   endtask

   task automatic random_traffic();
      int r;
      logic [`RAM_WORD_W-1:0] d;
      for (int i = 0; i < random_cycles; i++) begin
         r = $random(seed);
         d = $random(seed);
         if (r[0]) begin
            if (r[1]) begin
               drive_byte_write(random_base + byte_addr_t'(r[12:8]), d[7:0]);
            end else begin
               drive_word_write(random_base + byte_addr_t'(r[12:8]), d, r[7:4]);
            end
         end else begin
            // write fields still move while the strobe is low
            drive_word_write(random_base + byte_addr_t'(r[12:8]), d, r[7:4]);
            wr.en = 1'b0;
         end
         if (r[2] || r[3]) begin
            drive_read(random_base + byte_addr_t'(r[20:16]));
         end
         apply_cycle();
      end
   endtask

   initial begin
      seed = 32'hb354c2b5;
      err_count = 0;
      err_at_start = 0;
      tests_passed = 0;
      tests_failed = 0;
      rst = 1'b1;
      idle_inputs();
      repeat (reset_cycles) @(posedge clk);
      #(drive_delay);
      rst = 1'b0;
      fill_memory();

      drive_word_write(10'h040, 32'ha1b2c3d4, 4'hf);
      apply_cycle();
      read_word_bytes(10'h040);
      finish_test("full_word_write");

      drive_word_write(10'h044, 32'h11223344, 4'hf);
      apply_cycle();
      drive_word_write(10'h044, 32'hffeeddcc, 4'b0101);
      apply_cycle();
      read_word_bytes(10'h044);
      finish_test("partial_strobe");

      drive_byte_write(10'h04a, 8'h5e);
      apply_cycle();
      read_word_bytes(10'h048);
      finish_test("byte_write");

      // read and write of one word in the same cycle
      drive_read(10'h04d);
      drive_word_write(10'h04c, 32'h99887766, 4'hf);
      apply_cycle();
      drive_read(10'h04d);
      apply_cycle();
      finish_test("read_first");

      drive_read(10'h041);
      apply_cycle();
      repeat (4) apply_cycle();
      finish_test("read_hold");

      random_traffic();
      finish_test("random_mix");

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(total_cycles * 2 * clk_period);
      $display("timeout: tests did not finish within %0d cycles", total_cycles * 2);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- asym_ram_top.sv
`timescale 1ns/10ps
`include "asym_ram_macros.svh"

module asym_ram_top
   import ram_port_pkg::*;
   import ram_bank_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  wr_req_t                wr,
   input  rd_req_t                rd,
   output logic [`RAM_BYTE_W-1:0] r_data
);

   // buses between the port logic and the banks
   bank_wr_t   bank_wr;
   bank_rd_t   bank_rd;
   wide_word_u rd_lanes;

   // word or byte write into per-bank enables
   write_lane_steer write_lane_steer_i (
      .wr      (wr),
      .bank_wr (bank_wr)
   );

   // byte read, lane picked one cycle later
   read_lane_select read_lane_select_i (
      .clk      (clk),
      .rst      (rst),
      .rd       (rd),
      .rd_lanes (rd_lanes),
      .bank_rd  (bank_rd),
      .r_data   (r_data)
   );

   bank_array bank_array_i (
      .clk      (clk),
      .rst      (rst),
      .bank_wr  (bank_wr),
      .bank_rd  (bank_rd),
      .rd_lanes (rd_lanes)
   );

endmodule

//--- bank_array.sv
`timescale 1ns/10ps
`include "asym_ram_macros.svh"

module bank_array
   import ram_bank_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  bank_wr_t   bank_wr,
   input  bank_rd_t   bank_rd,
   output wide_word_u rd_lanes
);

   localparam int bank_depth = 1 << `RAM_WADDR_W;

   // registered read data, one entry per bank
   bank_byte_t lane_q [`RAM_LANES];

   genvar g;
   generate
      for (g = 0; g < `RAM_LANES; g++) begin : g_bank
         bank_byte_t mem [bank_depth];

         // write port, contents are never cleared
         always_ff @(posedge clk) begin
            if (bank_wr.en[g]) begin
               mem[bank_wr.addr] <= bank_wr.data.lane[g];
            end
         end

         // read port
         // nonblocking read sees the word before this edge's write
         always_ff @(posedge clk) begin
            if (rst) begin
               lane_q[g] <= '0;
            end else if (bank_rd.en) begin
               lane_q[g] <= mem[bank_rd.addr];
            end
         end
      end
   endgenerate

   // pack the bank outputs back into one word, lane 0 low
   always_comb begin
      for (int i = 0; i < `RAM_LANES; i++) begin
         rd_lanes.lane[i] = lane_q[i];
      end
   end

   // an X on the write address would scatter data over the bank
   property p_wr_addr_known;
      @(posedge clk) disable iff (rst)
         (|bank_wr.en) |-> !$isunknown(bank_wr.addr);
   endproperty

   a_wr_addr_known : assert property (p_wr_addr_known)
   else $error("bank write with unknown address, enables 0x%h", bank_wr.en);

endmodule

//--- read_lane_select.sv
`timescale 1ns/10ps
`include "asym_ram_macros.svh"

module read_lane_select
   import ram_port_pkg::*;
   import ram_bank_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  rd_req_t                rd,
   input  wide_word_u             rd_lanes,
   output bank_rd_t               bank_rd,
   output logic [`RAM_BYTE_W-1:0] r_data
);

   // lane of the read in flight, used when the banks answer
   lane_idx_t lane_q;
   lane_idx_t rd_lane;

   assign rd_lane = rd.addr[$bits(lane_idx_t)-1:0];

   // every bank reads the same word, the lane is picked afterwards
   always_comb begin
      bank_rd.en = rd.en;
      bank_rd.addr = rd.addr[`RAM_BADDR_W-1 -: `RAM_WADDR_W];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lane_q <= '0;
      end else if (rd.en) begin
         lane_q <= rd_lane;
      end
   end

   // bank outputs hold between reads, so does the selected byte
   assign r_data = rd_lanes.lane[lane_q];

   // lane index only moves right after a read strobe
   property p_lane_moves_on_read;
      @(posedge clk) disable iff (rst)
         !$past(rd.en) |-> $stable(lane_q);
   endproperty

   a_lane_moves_on_read : assert property (p_lane_moves_on_read)
   else $error("read lane changed to %0d without a read strobe", lane_q);

endmodule

//--- write_lane_steer.sv
`timescale 1ns/10ps
`include "asym_ram_macros.svh"

module write_lane_steer
   import ram_port_pkg::*;
   import ram_bank_pkg::*;
(
   input  wr_req_t  wr,
   output bank_wr_t bank_wr
);

   // upper address bits name the word, lower bits the lane
   word_addr_t word_addr;
   lane_idx_t  byte_lane;
   bank_byte_t byte_data;

   assign word_addr = wr.addr[`RAM_BADDR_W-1 -: `RAM_WADDR_W];
   assign byte_lane = wr.addr[$bits(lane_idx_t)-1:0];
   assign byte_data = wr.data[`RAM_BYTE_W-1:0];

   always_comb begin
      bank_wr.addr = word_addr;
      if (wr.size == size_word) begin
         // full word goes straight across, strobe picks the banks
         bank_wr.data.word = wr.data;
         bank_wr.en = wr.strb;
      end else begin
         // same byte on every lane, only one bank takes it
         for (int i = 0; i < `RAM_LANES; i++) begin
            bank_wr.data.lane[i] = byte_data;
         end
         bank_wr.en = '0;
         bank_wr.en[byte_lane] = 1'b1;
      end
      // nothing is written without the strobe
      if (!wr.en) begin
         bank_wr.en = '0;
      end
   end

   // checked on settled values, the block has no clock
   always_comb begin
      if (!wr.en) begin
         assert final (bank_wr.en == '0)
         else $error("bank write enable 0x%h without write strobe", bank_wr.en);
      end else if (wr.size == size_byte) begin
         assert final ($onehot(bank_wr.en))
         else $error("byte write enables 0x%h, expected one bank", bank_wr.en);
      end
   end

endmodule

//--- ram_bank_pkg.sv
`include "asym_ram_macros.svh"

package ram_bank_pkg;

   // address into one bank
   typedef logic [`RAM_WADDR_W-1:0] word_addr_t;

   // selects one of the banks, taken from the low byte address bits
   typedef logic [$clog2(`RAM_LANES)-1:0] lane_idx_t;

   // one bank data word
   typedef logic [`RAM_BYTE_W-1:0] bank_byte_t;

   // a word seen either flat or as byte lanes, lane 0 is the low byte
   typedef union packed {
      logic [`RAM_WORD_W-1:0]    word;
      bank_byte_t [`RAM_LANES-1:0] lane;
   } wide_word_u;

   // write bus shared by all banks
   // each bank picks its lane of data when its enable bit is set
   typedef struct packed {
      logic [`RAM_LANES-1:0] en;
      word_addr_t            addr;
      wide_word_u            data;
   } bank_wr_t;

   // read bus, same address to every bank
   typedef struct packed {
      logic       en;
      word_addr_t addr;
   } bank_rd_t;

endpackage

//--- ram_port_pkg.sv
`include "asym_ram_macros.svh"

package ram_port_pkg;

   // byte address as seen by both user ports
   typedef logic [`RAM_BADDR_W-1:0] byte_addr_t;

   // word writes take the full data word with a byte strobe,
   // byte writes take the low data byte at a byte address
   typedef enum logic {
      size_word = 1'b0,
      size_byte = 1'b1
   } wr_size_e;

   // write port request
   typedef struct packed {
      logic                   en;
      wr_size_e               size;
      byte_addr_t             addr;
      logic [`RAM_WORD_W-1:0] data;
      // only looked at for word writes
      logic [`RAM_LANES-1:0]  strb;
   } wr_req_t;

   // read port request, one byte back per strobe
   typedef struct packed {
      logic       en;
      byte_addr_t addr;
   } rd_req_t;

endpackage

//--- asym_ram_macros.svh
`ifndef ASYM_RAM_MACROS_SVH
`define ASYM_RAM_MACROS_SVH

// geometry of the asymmetric RAM
// the write side is one full word wide, the read side one byte wide

// number of byte banks making up a word
`define RAM_LANES 4

// data width of a single bank
`define RAM_BYTE_W 8

// write word width, RAM_LANES * RAM_BYTE_W
`define RAM_WORD_W 32

// word address width
// also sets the depth of every bank to 2**RAM_WADDR_W
`define RAM_WADDR_W 8

// byte address width, word address plus lane index bits
`define RAM_BADDR_W 10

`endif
